//--- cache_mem_pkg.sv
// cache memory package: address split constants and shared vector types
package cache_mem_pkg;

  //////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////

  // physical address width
  localparam int PLEN          = 32;

  // set index
  localparam int IDX_BITS      = 4;
  localparam int SETS          = 1 << IDX_BITS;   // 16 sets

  // line geometry
  localparam int LINE_BYTES    = 16;
  localparam int BLK_OFFS_BITS = $clog2(LINE_BYTES);  // byte offset in line
  localparam int LINE_BITS     = LINE_BYTES * 8;

  // write buffer word, replicated across the line on a write
  localparam int XLEN          = 32;

  // whatever is left above index and offset
  localparam int TAG_BITS      = PLEN - IDX_BITS - BLK_OFFS_BITS;

  //////////////////////////////////////////////////
  // associativity
  //////////////////////////////////////////////////

  // top level default, 1/4/8 ways also work
  localparam int DEFAULT_WAYS  = 2;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  // set index
  typedef logic [IDX_BITS-1:0]   idx_t;

  // address tag
  typedef logic [TAG_BITS-1:0]   tag_t;

  // one full cache line
  typedef logic [LINE_BITS-1:0]  line_t;

  // byte enables covering a line
  typedef logic [LINE_BYTES-1:0] line_be_t;

  // write buffer data word
  typedef logic [XLEN-1:0]       word_t;

  // physical address, tag/index/offset
  typedef logic [PLEN-1:0]       paddr_t;

endpackage

//--- cache_sram.sv
// single-port synchronous ram with byte enables and registered read
`timescale 1ns/1ps

module cache_sram #(
  parameter int DBITS = 8                       // multiple of 8
)
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  cache_mem_pkg::idx_t   addr_i,
  input  logic                  we_i,
  input  logic [DBITS/8-1:0]    be_i,
  input  logic [DBITS-1:0]      din_i,
  output logic [DBITS-1:0]      dout_o
);

  import cache_mem_pkg::*;

  logic [DBITS-1:0] mem_q [SETS];               // one word per set

  // byte lane writes
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      for (int b = 0; b < DBITS/8; b++)
      begin
        if (be_i[b])
        begin
          mem_q[addr_i][b*8 +: 8] <= din_i[b*8 +: 8];
        end
      end
    end
  end

  // read register, old data on a write cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      dout_o <= '0;
    end
    else
    begin
      dout_o <= mem_q[addr_i];
    end
  end

endmodule

//--- cache_tag_store.sv
// cache tag store: per-way tag rams, valid/dirty flops and tag compare
`timescale 1ns/1ps

module cache_tag_store #(
  parameter int WAYS = 2
)
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             lookup_i,
  input  logic                             fill_i,
  input  logic                             wb_write_i,
  input  logic                             evict_i,
  input  logic                             inval_all_i,
  input  logic                             fill_dirty_i,
  input  cache_mem_pkg::idx_t              idx_i,
  input  cache_mem_pkg::tag_t              tag_i,
  input  logic [WAYS-1:0]                  way_sel_i,     // one-hot
  output logic [WAYS-1:0]                  way_hit_o,
  output logic [WAYS-1:0]                  way_dirty_o,
  output logic                             any_dirty_o,
  output logic                             lookup_q_o,
  output logic                             evict_q_o,
  output cache_mem_pkg::tag_t [WAYS-1:0]   rd_tags_o,
  output cache_mem_pkg::idx_t              idx_q_o,
  output logic [WAYS-1:0]                  way_q_o
);

  import cache_mem_pkg::*;

  localparam int TAG_DBITS = ((TAG_BITS + 7) / 8) * 8;  // whole bytes

  logic [WAYS-1:0][SETS-1:0] valid_q;
  logic [WAYS-1:0][SETS-1:0] dirty_q;
  logic [TAG_DBITS-1:0]      tag_rd [WAYS];
  tag_t                      tag_q;               // lookup tag, aligned with ram out

  //////////////////////////////////////////////////
  // valid and dirty flags
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        if (inval_all_i)
        begin
          valid_q[w] <= '0;                       // dirty bits kept
        end
        else if (fill_i && way_sel_i[w])
        begin
          valid_q[w][idx_i] <= 1'b1;
        end
        // fill loads dirty from the bus, a wb write always dirties
        if ((fill_i || wb_write_i) && way_sel_i[w])
        begin
          dirty_q[w][idx_i] <= fill_i ? fill_dirty_i : 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // command delay, same latency as the rams
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      lookup_q_o  <= 1'b0;
      evict_q_o   <= 1'b0;
      any_dirty_o <= 1'b0;
    end
    else
    begin
      lookup_q_o <= lookup_i;
      evict_q_o  <= evict_i;
      if (lookup_i)
      begin
        any_dirty_o <= |(valid_q & dirty_q);      // whole cache, at the read
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    idx_q_o <= idx_i;
    way_q_o <= way_sel_i;
    tag_q   <= tag_i;
  end

  //////////////////////////////////////////////////
  // per way ram and compare
  //////////////////////////////////////////////////

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    cache_sram #(
      .DBITS  ( TAG_DBITS )
    ) u_tag_ram (
      .clk_i  ( clk_i                   ),
      .rst_ni ( rst_ni                  ),
      .addr_i ( idx_i                   ),
      .we_i   ( fill_i & way_sel_i[w]   ),
      .be_i   ( {(TAG_DBITS/8){1'b1}}   ),
      .din_i  ( TAG_DBITS'(tag_i)       ),
      .dout_o ( tag_rd[w]               )
    );

    assign rd_tags_o[w]   = tag_rd[w][TAG_BITS-1:0];
    // flags read at the delayed index, in step with the ram
    assign way_hit_o[w]   = valid_q[w][idx_q_o] & (rd_tags_o[w] == tag_q);
    assign way_dirty_o[w] = valid_q[w][idx_q_o] & dirty_q[w][idx_q_o];
  end

  // way select must name exactly one way
  a_way_sel_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fill_i || wb_write_i || evict_i) |-> $onehot(way_sel_i));

endmodule

//--- cache_data_store.sv
// cache data store: per-way line rams, line fill and byte-enabled word writes
`timescale 1ns/1ps

module cache_data_store #(
  parameter int WAYS = 2
)
(
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic                                                   fill_i,
  input  logic                                                   wb_write_i,
  input  cache_mem_pkg::idx_t                                    idx_i,
  input  logic [WAYS-1:0]                                        way_sel_i,
  input  cache_mem_pkg::line_t                                   fill_line_i,
  input  cache_mem_pkg::word_t                                   wb_word_i,
  input  logic [cache_mem_pkg::XLEN/8-1:0]                       wb_be_i,
  input  logic [$clog2(cache_mem_pkg::LINE_BITS/cache_mem_pkg::XLEN)-1:0] wb_offs_i,
  output cache_mem_pkg::line_t [WAYS-1:0]                        rd_lines_o
);

  import cache_mem_pkg::*;

  localparam int WORDS      = LINE_BITS / XLEN;   // words per line
  localparam int WORD_BYTES = XLEN / 8;

  line_t    wr_line;                              // ram write data
  line_be_t wr_be;                                // ram byte enables
  line_be_t wb_line_be;                           // word enables moved to offset
  logic     wr_en;

  //////////////////////////////////////////////////
  // write data and enables
  //////////////////////////////////////////////////

  // word enables shifted to their lane
  assign wb_line_be = line_be_t'(wb_be_i) << (wb_offs_i * WORD_BYTES);

  always_comb
  begin
    if (fill_i)
    begin
      wr_line = fill_line_i;                      // full line from bus
      wr_be   = '1;
    end
    else
    begin
      wr_line = {WORDS{wb_word_i}};               // word in every lane, be picks one
      wr_be   = wb_line_be;
    end
  end

  assign wr_en = fill_i | wb_write_i;

  //////////////////////////////////////////////////
  // line rams
  //////////////////////////////////////////////////

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    cache_sram #(
      .DBITS  ( LINE_BITS )
    ) u_data_ram (
      .clk_i  ( clk_i                  ),
      .rst_ni ( rst_ni                 ),
      .addr_i ( idx_i                  ),   // reads here when not writing
      .we_i   ( wr_en & way_sel_i[w]   ),
      .be_i   ( wr_be                  ),
      .din_i  ( wr_line                ),
      .dout_o ( rd_lines_o[w]          )
    );
  end

endmodule

//--- cache_result.sv
// cache result stage: hit line mux, evict select and registered outputs
`timescale 1ns/1ps

module cache_result #(
  parameter int WAYS = 2
)
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              lookup_q_i,
  input  logic                              evict_q_i,
  input  logic                              any_dirty_i,
  input  logic [WAYS-1:0]                   way_hit_i,
  input  logic [WAYS-1:0]                   way_dirty_i,
  input  logic [WAYS-1:0]                   way_q_i,      // one-hot evict way
  input  cache_mem_pkg::idx_t               idx_q_i,
  input  cache_mem_pkg::tag_t [WAYS-1:0]    rd_tags_i,
  input  cache_mem_pkg::line_t [WAYS-1:0]   rd_lines_i,
  output logic                              lookup_valid_o,
  output logic                              hit_o,
  output logic                              cache_dirty_o,
  output logic                              evict_valid_o,
  output logic [WAYS-1:0]                   ways_hit_o,
  output logic [WAYS-1:0]                   ways_dirty_o,
  output cache_mem_pkg::line_t              line_o,
  output cache_mem_pkg::paddr_t             evict_adr_o,
  output cache_mem_pkg::line_t              evict_line_o
);

  import cache_mem_pkg::*;

  line_t hit_line;                                // and-or of hitting ways
  line_t evict_line;
  tag_t  evict_tag;

  //////////////////////////////////////////////////
  // way muxes, and-or since selects are one-hot
  //////////////////////////////////////////////////

  always_comb
  begin
    hit_line   = '0;
    evict_line = '0;
    evict_tag  = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      hit_line   = hit_line   | (rd_lines_i[w] & {LINE_BITS{way_hit_i[w]}});
      evict_line = evict_line | (rd_lines_i[w] & {LINE_BITS{way_q_i[w]}});
      evict_tag  = evict_tag  | (rd_tags_i[w]  & {TAG_BITS{way_q_i[w]}});
    end
  end

  //////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////

  // valids and status flags
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      lookup_valid_o <= 1'b0;
      evict_valid_o  <= 1'b0;
      hit_o          <= 1'b0;
      cache_dirty_o  <= 1'b0;
      ways_hit_o     <= '0;
      ways_dirty_o   <= '0;
    end
    else
    begin
      lookup_valid_o <= lookup_q_i;               // one cycle pulse
      evict_valid_o  <= evict_q_i;
      if (lookup_q_i)
      begin
        hit_o         <= |way_hit_i;
        cache_dirty_o <= any_dirty_i;
        ways_hit_o    <= way_hit_i;
        ways_dirty_o  <= way_dirty_i;
      end
    end
  end

  // line payloads, held between valids
  always_ff @(posedge clk_i)
  begin
    if (lookup_q_i)
    begin
      line_o <= hit_line;
    end
    if (evict_q_i)
    begin
      evict_adr_o  <= {evict_tag, idx_q_i, {BLK_OFFS_BITS{1'b0}}};  // line aligned
      evict_line_o <= evict_line;
    end
  end

  // a tag can live in one way only, else the mux would blend lines
  a_hit_onehot0 : assert property (@(posedge clk_i) disable iff (!rst_ni)
    lookup_q_i |-> $onehot0(way_hit_i));

endmodule

//--- cache_mem_top.sv
// cache memory top level joining tag store, data store and result stage
`timescale 1ns/1ps

module cache_mem_top #(
  parameter int WAYS = cache_mem_pkg::DEFAULT_WAYS
)
(
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  // at most one command strobe per cycle
  input  logic                                                   lookup_i,
  input  logic                                                   fill_i,
  input  logic                                                   wb_write_i,
  input  logic                                                   evict_i,
  input  logic                                                   inval_all_i,
  // operands
  input  cache_mem_pkg::idx_t                                    idx_i,
  input  cache_mem_pkg::tag_t                                    tag_i,
  input  logic [WAYS-1:0]                                        way_sel_i,
  input  cache_mem_pkg::line_t                                   fill_line_i,
  input  logic                                                   fill_dirty_i,
  input  cache_mem_pkg::word_t                                   wb_word_i,
  input  logic [cache_mem_pkg::XLEN/8-1:0]                       wb_be_i,
  input  logic [$clog2(cache_mem_pkg::LINE_BITS/cache_mem_pkg::XLEN)-1:0] wb_offs_i,
  // lookup result
  output logic                                                   lookup_valid_o,
  output logic                                                   hit_o,
  output logic [WAYS-1:0]                                        ways_hit_o,
  output logic                                                   cache_dirty_o,
  output logic [WAYS-1:0]                                        ways_dirty_o,
  output cache_mem_pkg::line_t                                   line_o,
  // evict result
  output logic                                                   evict_valid_o,
  output cache_mem_pkg::paddr_t                                  evict_adr_o,
  output cache_mem_pkg::line_t                                   evict_line_o
);

  import cache_mem_pkg::*;

  logic [WAYS-1:0]   way_hit;
  logic [WAYS-1:0]   way_dirty;
  logic              any_dirty;
  logic              lookup_q;
  logic              evict_q;
  tag_t [WAYS-1:0]   rd_tags;
  line_t [WAYS-1:0]  rd_lines;
  idx_t              idx_q;
  logic [WAYS-1:0]   way_q;

  cache_tag_store #(
    .WAYS         ( WAYS         )
  ) u_tag (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .lookup_i     ( lookup_i     ),
    .fill_i       ( fill_i       ),
    .wb_write_i   ( wb_write_i   ),
    .evict_i      ( evict_i      ),
    .inval_all_i  ( inval_all_i  ),
    .fill_dirty_i ( fill_dirty_i ),
    .idx_i        ( idx_i        ),
    .tag_i        ( tag_i        ),
    .way_sel_i    ( way_sel_i    ),
    .way_hit_o    ( way_hit      ),
    .way_dirty_o  ( way_dirty    ),
    .any_dirty_o  ( any_dirty    ),
    .lookup_q_o   ( lookup_q     ),
    .evict_q_o    ( evict_q      ),
    .rd_tags_o    ( rd_tags      ),
    .idx_q_o      ( idx_q        ),
    .way_q_o      ( way_q        )
  );

  cache_data_store #(
    .WAYS         ( WAYS         )
  ) u_data (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .fill_i       ( fill_i       ),
    .wb_write_i   ( wb_write_i   ),
    .idx_i        ( idx_i        ),
    .way_sel_i    ( way_sel_i    ),
    .fill_line_i  ( fill_line_i  ),
    .wb_word_i    ( wb_word_i    ),
    .wb_be_i      ( wb_be_i      ),
    .wb_offs_i    ( wb_offs_i    ),
    .rd_lines_o   ( rd_lines     )
  );

  cache_result #(
    .WAYS           ( WAYS           )
  ) u_result (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .lookup_q_i     ( lookup_q       ),
    .evict_q_i      ( evict_q        ),
    .any_dirty_i    ( any_dirty      ),
    .way_hit_i      ( way_hit        ),
    .way_dirty_i    ( way_dirty      ),
    .way_q_i        ( way_q          ),
    .idx_q_i        ( idx_q          ),
    .rd_tags_i      ( rd_tags        ),
    .rd_lines_i     ( rd_lines       ),
    .lookup_valid_o ( lookup_valid_o ),
    .hit_o          ( hit_o          ),
    .cache_dirty_o  ( cache_dirty_o  ),
    .evict_valid_o  ( evict_valid_o  ),
    .ways_hit_o     ( ways_hit_o     ),
    .ways_dirty_o   ( ways_dirty_o   ),
    .line_o         ( line_o         ),
    .evict_adr_o    ( evict_adr_o    ),
    .evict_line_o   ( evict_line_o   )
  );

  //////////////////////////////////////////////////
  // protocol checks
  //////////////////////////////////////////////////

  // one command per cycle
  a_one_cmd : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({lookup_i, fill_i, wb_write_i, evict_i, inval_all_i}));

endmodule

//--- tb_cache_mem_top.sv
// cache memory testbench checking random commands against a line model
`timescale 1ns/1ps

module tb_cache_mem_top;

  import cache_mem_pkg::*;

  localparam int WAYS      = 2;
  localparam int OFFS_BITS = $clog2(LINE_BITS / XLEN);
  localparam int N_T1      = 16;                  // lookups after reset
  localparam int N_T2      = 24;                  // fill, hit lookup, miss lookup
  localparam int N_T3      = 32;                  // write, lookup
  localparam int N_T4      = 16;                  // evicts
  localparam int N_T5      = 16;                  // lookups after invalidate
  localparam int N_MIX     = 300;
  localparam int N_CMDS    = N_T1 + 4 + 3 * N_T2 + 2 * N_T3 + N_T4 + 1 + N_T5 + N_MIX;
  localparam int WD_CYCLES = 2 * N_CMDS + 100;

  // one predicted lookup or evict result
  typedef struct packed {
    logic            is_evict;
    logic [31:0]     cyc;                         // cycle the valid must show in
    logic            hit;
    logic [WAYS-1:0] ways_hit;
    logic            dirty;
    logic [WAYS-1:0] ways_dirty;
    line_t           line;
    paddr_t          adr;
  } exp_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 lookup_i, fill_i, wb_write_i, evict_i, inval_all_i;
  idx_t                 idx_i;
  tag_t                 tag_i;
  logic [WAYS-1:0]      way_sel_i;
  line_t                fill_line_i;
  logic                 fill_dirty_i;
  word_t                wb_word_i;
  logic [XLEN/8-1:0]    wb_be_i;
  logic [OFFS_BITS-1:0] wb_offs_i;
  logic                 lookup_valid_o, hit_o, cache_dirty_o, evict_valid_o;
  logic [WAYS-1:0]      ways_hit_o, ways_dirty_o;
  line_t                line_o;
  paddr_t               evict_adr_o;
  line_t                evict_line_o;

  //////////////////////////////////////////////////
  // model state
  //////////////////////////////////////////////////

  tag_t  m_tag    [WAYS][SETS];
  logic  m_valid  [WAYS][SETS];
  logic  m_dirty  [WAYS][SETS];
  logic  m_filled [WAYS][SETS];                   // ram holds a known line
  line_t m_line   [WAYS][SETS];
  exp_t  exp_q [$];
  exp_t  got_e;
  int    cyc = 0;
  int    checks = 0;
  int    errors = 0;
  int    test_num = 0;
  int    test_start = 0;

  cache_mem_top #(
    .WAYS           ( WAYS           )
  ) u_dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .lookup_i       ( lookup_i       ),
    .fill_i         ( fill_i         ),
    .wb_write_i     ( wb_write_i     ),
    .evict_i        ( evict_i        ),
    .inval_all_i    ( inval_all_i    ),
    .idx_i          ( idx_i          ),
    .tag_i          ( tag_i          ),
    .way_sel_i      ( way_sel_i      ),
    .fill_line_i    ( fill_line_i    ),
    .fill_dirty_i   ( fill_dirty_i   ),
    .wb_word_i      ( wb_word_i      ),
    .wb_be_i        ( wb_be_i        ),
    .wb_offs_i      ( wb_offs_i      ),
    .lookup_valid_o ( lookup_valid_o ),
    .hit_o          ( hit_o          ),
    .ways_hit_o     ( ways_hit_o     ),
    .cache_dirty_o  ( cache_dirty_o  ),
    .ways_dirty_o   ( ways_dirty_o   ),
    .line_o         ( line_o         ),
    .evict_valid_o  ( evict_valid_o  ),
    .evict_adr_o    ( evict_adr_o    ),
    .evict_line_o   ( evict_line_o   )
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;                      // 100 ns period

  always @(posedge clk_i) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input line_t got, input line_t exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("** Error %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic clear_cmd();
    lookup_i    = 1'b0;
    fill_i      = 1'b0;
    wb_write_i  = 1'b0;
    evict_i     = 1'b0;
    inval_all_i = 1'b0;
  endtask

  function automatic line_t rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // a tag valid in another way at this set must be refilled there
  function automatic int pick_fill_way(idx_t idx, tag_t tag, int w);
    for (int v = 0; v < WAYS; v++)
    begin
      if (m_valid[v][idx] && m_tag[v][idx] == tag)
      begin
        return v;
      end
    end
    return w;
  endfunction

  function automatic exp_t predict_lookup(idx_t idx, tag_t tag);
    exp_t e;
    e     = '0;
    e.cyc = 32'(cyc + 2);                         // valid two edges after sampling
    for (int w = 0; w < WAYS; w++)
    begin
      for (int s = 0; s < SETS; s++)
      begin
        if (m_valid[w][s] && m_dirty[w][s])
        begin
          e.dirty = 1'b1;
        end
      end
      if (m_valid[w][idx] && m_tag[w][idx] == tag)
      begin
        e.hit         = 1'b1;
        e.ways_hit[w] = 1'b1;
        e.line        = m_line[w][idx];
      end
      e.ways_dirty[w] = m_valid[w][idx] & m_dirty[w][idx];
    end
    return e;
  endfunction

  //////////////////////////////////////////////////
  // commands driven on the falling edge
  //////////////////////////////////////////////////

  task automatic issue_lookup(input idx_t idx, input tag_t tag);
    @(negedge clk_i);
    clear_cmd();
    lookup_i = 1'b1;
    idx_i    = idx;
    tag_i    = tag;
    exp_q.push_back(predict_lookup(idx, tag));
  endtask

  task automatic load_line(input idx_t idx, input int w, input tag_t tag, input logic dirty);
    int    fw;
    line_t ln;
    fw = pick_fill_way(idx, tag, w);
    ln = rand_line();
    @(negedge clk_i);
    clear_cmd();
    fill_i       = 1'b1;
    idx_i        = idx;
    tag_i        = tag;
    way_sel_i    = WAYS'(1 << fw);
    fill_line_i  = ln;
    fill_dirty_i = dirty;
    // model runs half a cycle ahead of the dut
    m_tag[fw][idx]    = tag;
    m_valid[fw][idx]  = 1'b1;
    m_dirty[fw][idx]  = dirty;
    m_filled[fw][idx] = 1'b1;
    m_line[fw][idx]   = ln;
  endtask

  task automatic write_word(input idx_t idx, input int w);
    word_t                wd;
    logic [XLEN/8-1:0]    be;
    logic [OFFS_BITS-1:0] offs;
    if (!m_filled[w][idx])
    begin
      load_line(idx, w, tag_t'($urandom), 1'b0);  // unknown line gets filled first
    end
    else
    begin
      wd   = word_t'($urandom);
      be   = (XLEN/8)'($urandom_range(1, 15));
      offs = OFFS_BITS'($urandom_range(0, 3));
      @(negedge clk_i);
      clear_cmd();
      wb_write_i = 1'b1;
      idx_i      = idx;
      way_sel_i  = WAYS'(1 << w);
      wb_word_i  = wd;
      wb_be_i    = be;
      wb_offs_i  = offs;
      for (int k = 0; k < XLEN/8; k++)
      begin
        if (be[k])
        begin
          m_line[w][idx][(int'(offs) * 4 + k) * 8 +: 8] = wd[k*8 +: 8];
        end
      end
      m_dirty[w][idx] = 1'b1;
    end
  endtask

  task automatic read_evict(input idx_t idx, input int w);
    exp_t e;
    if (!m_filled[w][idx])
    begin
      load_line(idx, w, tag_t'($urandom), 1'b1);
    end
    else
    begin
      @(negedge clk_i);
      clear_cmd();
      evict_i   = 1'b1;
      idx_i     = idx;
      way_sel_i = WAYS'(1 << w);
      e          = '0;
      e.is_evict = 1'b1;
      e.cyc      = 32'(cyc + 2);
      e.adr      = {m_tag[w][idx], idx, {BLK_OFFS_BITS{1'b0}}};
      e.line     = m_line[w][idx];
      exp_q.push_back(e);
    end
  endtask

  task automatic invalidate_all();
    @(negedge clk_i);
    clear_cmd();
    inval_all_i = 1'b1;
    for (int w = 0; w < WAYS; w++)
    begin
      for (int s = 0; s < SETS; s++)
      begin
        m_valid[w][s] = 1'b0;                     // tags, lines, dirty kept
      end
    end
  endtask

  // drain outstanding results and report the test
  task automatic end_test(input string name);
    @(negedge clk_i);
    clear_cmd();
    while (exp_q.size() != 0)
    begin
      @(negedge clk_i);
    end
    test_num++;
    $display("test %0d %s: %s, %0d errors", test_num, name,
             (errors == test_start) ? "ok" : "failed", errors - test_start);
    test_start = errors;
  endtask

  //////////////////////////////////////////////////
  // result monitor sampling where outputs are stable
  //////////////////////////////////////////////////

  always @(negedge clk_i)
  begin
    if (rst_ni && (lookup_valid_o || evict_valid_o))
    begin
      checks++;
      assert (exp_q.size() != 0)
      else
      begin
        $display("a result valid came with no command outstanding at cycle %0d", cyc);
        errors++;
      end
      if (exp_q.size() != 0)
      begin
        got_e = exp_q.pop_front();
        assert (got_e.is_evict == evict_valid_o && int'(got_e.cyc) == cyc)
        else
        begin
          $display("result of the wrong kind or at cycle %0d instead of %0d", cyc, got_e.cyc);
          errors++;
        end
        if (!got_e.is_evict)
        begin
          check_val("hit_o", line_t'(hit_o), line_t'(got_e.hit));
          check_val("ways_hit_o", line_t'(ways_hit_o), line_t'(got_e.ways_hit));
          check_val("cache_dirty_o", line_t'(cache_dirty_o), line_t'(got_e.dirty));
          check_val("ways_dirty_o", line_t'(ways_dirty_o), line_t'(got_e.ways_dirty));
          if (got_e.hit)
          begin
            check_val("line_o", line_o, got_e.line);
          end
        end
        else
        begin
          check_val("evict_adr_o", line_t'(evict_adr_o), line_t'(got_e.adr));
          check_val("evict_line_o", evict_line_o, got_e.line);
        end
      end
    end
  end

  // watchdog sized from the command count
  initial
  begin
    repeat (WD_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles with results outstanding", WD_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    void'($urandom(22282));                       // one seed for the run
    rst_ni       = 1'b0;
    clear_cmd();
    idx_i        = '0;
    tag_i        = '0;
    way_sel_i    = '0;
    fill_line_i  = '0;
    fill_dirty_i = 1'b0;
    wb_word_i    = '0;
    wb_be_i      = '0;
    wb_offs_i    = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      for (int s = 0; s < SETS; s++)
      begin
        m_tag[w][s]    = '0;
        m_valid[w][s]  = 1'b0;
        m_dirty[w][s]  = 1'b0;
        m_filled[w][s] = 1'b0;
        m_line[w][s]   = '0;
      end
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // test 1 expects quiet valids after reset and misses everywhere
    repeat (4)
    begin
      @(negedge clk_i);
      checks++;
      assert (!lookup_valid_o && !evict_valid_o)
      else
      begin
        $display("a result valid rose after reset with no command issued");
        errors++;
      end
    end
    for (int i = 0; i < N_T1; i++)
    begin
      issue_lookup(idx_t'(i), tag_t'($urandom));
    end
    end_test("valids after reset");

    // test 2 fills and hits on the same tag, misses on another
    for (int i = 0; i < N_T2; i++)
    begin
      idx_t ix;
      tag_t tg;
      ix = idx_t'($urandom_range(0, 3));
      tg = tag_t'($urandom);
      load_line(ix, $urandom_range(0, WAYS - 1), tg, 1'($urandom_range(0, 1)));
      issue_lookup(ix, tg);
      issue_lookup(ix, tg ^ tag_t'(24'h800001));
    end
    end_test("fill then lookup");

    // test 3 writes enabled bytes and checks them with the next lookup
    for (int i = 0; i < N_T3; i++)
    begin
      idx_t ix;
      int   w;
      ix = idx_t'($urandom_range(0, 3));
      w  = $urandom_range(0, WAYS - 1);
      write_word(ix, w);
      issue_lookup(ix, m_tag[w][ix]);
    end
    end_test("write-buffer writes");

    // test 4 reads out evicted lines
    for (int i = 0; i < N_T4; i++)
    begin
      read_evict(idx_t'($urandom_range(0, 3)), $urandom_range(0, WAYS - 1));
    end
    end_test("eviction");

    // test 5 invalidates all so stored tags miss
    invalidate_all();
    for (int i = 0; i < N_T5; i++)
    begin
      idx_t ix;
      ix = idx_t'($urandom_range(0, 3));
      issue_lookup(ix, m_tag[$urandom_range(0, WAYS - 1)][ix]);
    end
    end_test("invalidate all");

    // test 6 runs a back-to-back random mix over a small tag space
    for (int i = 0; i < N_MIX; i++)
    begin
      int   op;
      int   w;
      idx_t ix;
      op = $urandom_range(0, 19);
      w  = $urandom_range(0, WAYS - 1);
      ix = idx_t'($urandom_range(0, 3));
      if (op < 8)
      begin
        issue_lookup(ix, ($urandom_range(0, 1) != 0) ? m_tag[w][ix]
                                                      : tag_t'($urandom_range(0, 3)));
      end
      else if (op < 12)
      begin
        load_line(ix, w, tag_t'($urandom_range(0, 3)), 1'($urandom_range(0, 1)));
      end
      else if (op < 16)
      begin
        write_word(ix, w);
      end
      else if (op < 19)
      begin
        read_evict(ix, w);
      end
      else
      begin
        invalidate_all();
      end
    end
    end_test("random mix");

    $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
    if (errors == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- cache_mem_top.f
cache_mem_pkg.sv
cache_sram.sv
cache_tag_store.sv
cache_data_store.sv
cache_result.sv
cache_mem_top.sv
tb_cache_mem_top.sv

//--- Makefile
# Verilator build and run for the cache memory testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_cache_mem_top
FILELIST  := cache_mem_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
